// File: Makefile
# Verilator build and run for the NoC switch output stage.
# Override any variable on the command line, e.g. make TOP=nocSwitchTb OBJ_DIR=build

VERILATOR  ?= verilator
TOP        ?= nocSwitchTb
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -Wno-fatal -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing --assert
SIM_ARGS   ?=

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: run build lint clean

# default target, the simulator exit status is the test result
run: build
	./$(SIM_BIN) $(SIM_ARGS)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
+incdir+verification
src/nocFlitPkg.sv
src/nocArbPkg.sv
src/inputPort.sv
src/packetTimer.sv
src/portArbiter.sv
src/crossbarOutput.sv
src/nocSwitch.sv
verification/nocSwitchTb.sv

// File: src/crossbarOutput.sv
`timescale 1ns/1ps

module crossbarOutput (
  input  logic                                            clk,
  input  logic                                            rst,
  input  logic                                            grantValid,
  input  nocArbPkg::portIdx_t                             grantPort,
  input  nocFlitPkg::flitData_t [nocArbPkg::NUM_PORTS-1:0] headFlit,
  input  nocFlitPkg::flitId_t [nocArbPkg::NUM_PORTS-1:0]  headId,
  output nocFlitPkg::flitData_t                           outFlit,
  output nocFlitPkg::flitId_t                             outId,
  output nocArbPkg::portIdx_t                             outPort,
  output logic                                            outValid
);

  // ====================
  // control
  // ====================

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
      outId    <= nocFlitPkg::FLIT_IDLE;
    end
    else
    begin
      outValid <= grantValid;
      if (grantValid)
        outId <= headId[grantPort];
      else
        outId <= nocFlitPkg::FLIT_IDLE; // line shows idle between flits.
    end
  end

  // ====================
  // payload
  // ====================

  always_ff @(posedge clk)
  begin
    if (grantValid)
    begin
      outFlit <= headFlit[grantPort];
      outPort <= grantPort; // source port of this flit.
    end
  end

endmodule

// File: src/inputPort.sv
`timescale 1ns/1ps

module inputPort #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                      clk,
  input  logic                      rst,
  input  nocFlitPkg::flitData_t     flitIn,
  input  nocFlitPkg::flitId_t       flitIdIn,
  input  nocFlitPkg::packetLength_t lengthIn,
  input  logic                      flitValid,
  input  logic                      pop,
  output logic                      full,
  output logic                      req,
  output nocFlitPkg::flitData_t     headFlit,
  output nocFlitPkg::flitId_t       headId,
  output nocFlitPkg::packetLength_t headLength
);

  localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);
  localparam int CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

  nocFlitPkg::flitData_t     flitMem   [FIFO_DEPTH];
  nocFlitPkg::flitId_t       idMem     [FIFO_DEPTH];
  nocFlitPkg::packetLength_t lengthMem [FIFO_DEPTH];

  logic [PTR_WIDTH-1:0] wrPtr;
  logic [PTR_WIDTH-1:0] rdPtr;
  logic [CNT_WIDTH-1:0] count;
  logic                 doWrite;
  logic                 doRead;

  assign full    = (count == CNT_WIDTH'(FIFO_DEPTH));
  assign req     = (count != '0);
  assign doWrite = flitValid && !full; // writes into a full queue are lost.
  assign doRead  = pop && req;

  // head entry, no read latency.
  assign headFlit   = flitMem[rdPtr];
  assign headId     = idMem[rdPtr];
  assign headLength = lengthMem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (doWrite)
    begin
      flitMem[wrPtr]   <= flitIn;
      idMem[wrPtr]     <= flitIdIn;
      lengthMem[wrPtr] <= lengthIn;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doWrite)
        wrPtr <= (wrPtr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      if (doRead)
        rdPtr <= (rdPtr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      case ({doWrite, doRead})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // the arbiter only pops a port that is requesting.
  popWhileEmpty: assert property (@(posedge clk) disable iff (rst) pop |-> req)
    else $error("inputPort: pop on empty queue");

endmodule

// File: src/nocArbPkg.sv
package nocArbPkg;

  // ====================
  // ports
  // ====================

  localparam int NUM_PORTS = 5;

  typedef logic [2:0] portIdx_t;

  localparam portIdx_t PORT_L = 3'd0; // local.
  localparam portIdx_t PORT_N = 3'd1;
  localparam portIdx_t PORT_E = 3'd2;
  localparam portIdx_t PORT_W = 3'd3;
  localparam portIdx_t PORT_S = 3'd4;

  // ====================
  // arbiter states
  // ====================

  // port p owns bit p+1, bit 0 is idle.
  typedef enum logic [5:0] {
    ST_IDLE = 6'b000001,
    ST_L    = 6'b000010,
    ST_N    = 6'b000100,
    ST_E    = 6'b001000,
    ST_W    = 6'b010000,
    ST_S    = 6'b100000
  } grantState_e;

endpackage

// File: src/nocFlitPkg.sv
package nocFlitPkg;

  // ====================
  // flit fields
  // ====================

  typedef logic [31:0] flitData_t;     // flit payload.
  typedef logic [2:0]  flitId_t;       // flit identifier.
  typedef logic [11:0] packetLength_t; // flits per packet, header included.

  // ====================
  // flit identifier codes
  // ====================

  localparam flitId_t FLIT_IDLE   = 3'd0; // no flit.
  localparam flitId_t FLIT_HEADER = 3'd1; // first flit, carries the length.
  localparam flitId_t FLIT_BODY   = 3'd2;
  localparam flitId_t FLIT_TAIL   = 3'd3; // last flit of a packet.

endpackage

// File: src/nocSwitch.sv
`timescale 1ns/1ps

module nocSwitch #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                                                 clk,
  input  logic                                                 rst,
  input  nocFlitPkg::flitData_t [nocArbPkg::NUM_PORTS-1:0]     flitIn,
  input  nocFlitPkg::flitId_t [nocArbPkg::NUM_PORTS-1:0]       flitIdIn,
  input  nocFlitPkg::packetLength_t [nocArbPkg::NUM_PORTS-1:0] lengthIn,
  input  logic [nocArbPkg::NUM_PORTS-1:0]                      flitValid,
  output logic [nocArbPkg::NUM_PORTS-1:0]                      full,
  output nocFlitPkg::flitData_t                                outFlit,
  output nocFlitPkg::flitId_t                                  outId,
  output nocArbPkg::portIdx_t                                  outPort,
  output logic                                                 outValid
);

  logic [nocArbPkg::NUM_PORTS-1:0]                      req;
  logic [nocArbPkg::NUM_PORTS-1:0]                      pop;
  nocFlitPkg::flitData_t [nocArbPkg::NUM_PORTS-1:0]     headFlit;
  nocFlitPkg::flitId_t [nocArbPkg::NUM_PORTS-1:0]       headId;
  nocFlitPkg::packetLength_t [nocArbPkg::NUM_PORTS-1:0] headLength;
  logic                                                 grantValid;
  nocArbPkg::portIdx_t                                  grantPort;

  // ====================
  // input queues
  // ====================

  for (genvar p = 0; p < nocArbPkg::NUM_PORTS; p++)
  begin : portGen
    inputPort #(
      .FIFO_DEPTH (FIFO_DEPTH)
    ) port_i (
      .clk        (clk),
      .rst        (rst),
      .flitIn     (flitIn[p]),
      .flitIdIn   (flitIdIn[p]),
      .lengthIn   (lengthIn[p]),
      .flitValid  (flitValid[p]),
      .pop        (pop[p]),
      .full       (full[p]),
      .req        (req[p]),
      .headFlit   (headFlit[p]),
      .headId     (headId[p]),
      .headLength (headLength[p])
    );
  end

  // ====================
  // arbiter and output
  // ====================

  portArbiter arb_i (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .headId     (headId),
    .headLength (headLength),
    .pop        (pop),
    .grantValid (grantValid),
    .grantPort  (grantPort)
  );

  crossbarOutput xbar_i (
    .clk        (clk),
    .rst        (rst),
    .grantValid (grantValid),
    .grantPort  (grantPort),
    .headFlit   (headFlit),
    .headId     (headId),
    .outFlit    (outFlit),
    .outId      (outId),
    .outPort    (outPort),
    .outValid   (outValid)
  );

endmodule

// File: src/packetTimer.sv
`timescale 1ns/1ps

module packetTimer (
  input  logic                      clk,
  input  logic                      rst,
  input  nocFlitPkg::flitId_t       headId,
  input  nocFlitPkg::packetLength_t headLength,
  input  logic                      runTimer,
  output logic                      timesUp
);

  nocFlitPkg::packetLength_t timeout; // grant length from the last header.
  nocFlitPkg::packetLength_t count;   // pops in the current grant.

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      timeout <= '0;
      count   <= '0;
      timesUp <= 1'b0;
    end
    else
    begin
      if (headId == nocFlitPkg::FLIT_HEADER)
        timeout <= headLength;
      if (runTimer)
      begin
        count   <= count + 1'b1;
        timesUp <= (count + 1'b1 == timeout); // this pop is the last one.
      end
      else
      begin
        count   <= '0;
        timesUp <= 1'b0;
      end
    end
  end

endmodule

// File: src/portArbiter.sv
`timescale 1ns/1ps

module portArbiter (
  input  logic                                                  clk,
  input  logic                                                  rst,
  input  logic [nocArbPkg::NUM_PORTS-1:0]                       req,
  input  nocFlitPkg::flitId_t [nocArbPkg::NUM_PORTS-1:0]        headId,
  input  nocFlitPkg::packetLength_t [nocArbPkg::NUM_PORTS-1:0]  headLength,
  output logic [nocArbPkg::NUM_PORTS-1:0]                       pop,
  output logic                                                  grantValid,
  output nocArbPkg::portIdx_t                                   grantPort
);

  nocArbPkg::grantState_e                state;
  nocArbPkg::grantState_e                nextState;
  nocArbPkg::portIdx_t                   curPort;
  logic                                  granted;
  logic                                  hold;
  logic [nocArbPkg::NUM_PORTS-1:0]       runTimer;
  logic [nocArbPkg::NUM_PORTS-1:0]       timesUp;

  // first requester after 'from', 'from' itself last.
  function automatic nocArbPkg::grantState_e nextRequester(
    input nocArbPkg::portIdx_t             from,
    input logic [nocArbPkg::NUM_PORTS-1:0] reqs
  );
    nocArbPkg::grantState_e pick;
    int                     idx;
    pick = nocArbPkg::ST_IDLE;
    // walk from far to near so the nearest requester wins.
    for (int i = nocArbPkg::NUM_PORTS; i >= 1; i--)
    begin
      idx = (int'(from) + i) % nocArbPkg::NUM_PORTS;
      if (reqs[idx])
        pick = nocArbPkg::grantState_e'(6'b000010 << idx);
    end
    return pick;
  endfunction

  // ====================
  // packet timers
  // ====================

  for (genvar p = 0; p < nocArbPkg::NUM_PORTS; p++)
  begin : timerGen
    packetTimer timer_i (
      .clk        (clk),
      .rst        (rst),
      .headId     (headId[p]),
      .headLength (headLength[p]),
      .runTimer   (runTimer[p]),
      .timesUp    (timesUp[p])
    );
  end

  // ====================
  // grant FSM
  // ====================

  always_comb
  begin
    granted = 1'b1;
    case (state)
      nocArbPkg::ST_L: curPort = nocArbPkg::PORT_L;
      nocArbPkg::ST_N: curPort = nocArbPkg::PORT_N;
      nocArbPkg::ST_E: curPort = nocArbPkg::PORT_E;
      nocArbPkg::ST_W: curPort = nocArbPkg::PORT_W;
      nocArbPkg::ST_S: curPort = nocArbPkg::PORT_S;
      default:
      begin
        granted = 1'b0;
        curPort = nocArbPkg::PORT_S; // rotation from idle starts at L.
      end
    endcase
  end

  assign hold = granted && req[curPort] && !timesUp[curPort];

  always_comb
  begin
    for (int p = 0; p < nocArbPkg::NUM_PORTS; p++)
      pop[p] = hold && (curPort == nocArbPkg::portIdx_t'(p));
  end

  assign runTimer   = pop;
  assign grantValid = hold;
  assign grantPort  = curPort;

  always_comb
  begin
    if (hold)
      nextState = state;
    else
      nextState = nextRequester(curPort, req); // one cycle without pop.
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= nocArbPkg::ST_IDLE;
    else
      state <= nextState;
  end

  stateOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(state))
    else $error("portArbiter: state not one-hot");

  singlePop: assert property (@(posedge clk) disable iff (rst) $onehot0(pop))
    else $error("portArbiter: more than one pop");

endmodule

// File: verification/nocSwitchTests.svh
// ====================
// stimulus helpers
// ====================

// random payloads, header first and tail last.
task automatic makePacket(input nocArbPkg::portIdx_t port, input int nFlits, input int len);
  for (int i = 0; i < nFlits; i++)
  begin
    stimData[port][i] = $random(seed);
    if (i == 0)
      stimId[port][i] = nocFlitPkg::FLIT_HEADER;
    else if (i == nFlits - 1)
      stimId[port][i] = nocFlitPkg::FLIT_TAIL;
    else
      stimId[port][i] = nocFlitPkg::FLIT_BODY;
  end
  stimLen[port]   = nocFlitPkg::packetLength_t'(len);
  stimCount[port] = nFlits;
endtask

task automatic driveFlit(input nocArbPkg::portIdx_t port, input int idx);
  flitIn[port]    = stimData[port][idx];
  flitIdIn[port]  = stimId[port][idx];
  lengthIn[port]  = (idx == 0) ? stimLen[port] : '0; // length only rides on the header.
  flitValid[port] = 1'b1;
endtask

// holds each flit back while the queue is full.
task automatic sendPacket(input nocArbPkg::portIdx_t port);
  for (int i = 0; i < stimCount[port]; i++)
  begin
    @(negedge clk);
    while (full[port])
    begin
      flitValid[port] = 1'b0;
      @(negedge clk);
    end
    driveFlit(port, i);
  end
  @(negedge clk);
  flitValid[port] = 1'b0;
endtask

// back to back writes, full is expected once depth flits are queued.
task automatic burstPacket(input string testName, input nocArbPkg::portIdx_t port,
                           input int depth);
  for (int i = 0; i < stimCount[port]; i++)
  begin
    @(negedge clk);
    checkValue(testName, $sformatf("full before write %0d", i),
               32'(i >= depth), 32'(full[port]));
    driveFlit(port, i);
  end
  @(negedge clk);
  flitValid[port] = 1'b0;
endtask

// ====================
// output bookkeeping
// ====================

task automatic startTest();
  repeat (4) @(negedge clk); // arbiter back to idle.
  expData.delete();
  expId.delete();
  expPort.delete();
  recvData.delete();
  recvId.delete();
  recvPort.delete();
endtask

task automatic expectFlits(input nocArbPkg::portIdx_t port, input int first, input int count);
  for (int i = first; i < first + count; i++)
  begin
    expData.push_back(stimData[port][i]);
    expId.push_back(stimId[port][i]);
    expPort.push_back(port);
  end
endtask

task automatic waitForFlits(input int count);
  while (recvData.size() < count)
    @(posedge clk);
endtask

task automatic checkRecords(input string testName);
  repeat (QUIET_CYCLES) @(posedge clk); // late or extra flits show up here.
  checkValue(testName, "flit count", 32'(expData.size()), 32'(recvData.size()));
  for (int i = 0; i < expData.size(); i++)
  begin
    checkValue(testName, $sformatf("flit %0d port", i), 32'(expPort[i]), 32'(recvPort[i]));
    checkValue(testName, $sformatf("flit %0d id", i), 32'(expId[i]), 32'(recvId[i]));
    checkValue(testName, $sformatf("flit %0d data", i), expData[i], recvData[i]);
  end
endtask

// ====================
// directed tests
// ====================

task automatic singlePacketTest();
  string name;
  name = "singlePacket";
  @(negedge clk);
  checkValue(name, "outValid after reset", 32'(0), 32'(outValid));
  checkValue(name, "full after reset", 32'(0), 32'(full));
  for (int p = 0; p < nocArbPkg::NUM_PORTS; p++)
  begin
    startTest();
    makePacket(nocArbPkg::portIdx_t'(p), p + 2, p + 2);
    sendPacket(nocArbPkg::portIdx_t'(p));
    expectFlits(nocArbPkg::portIdx_t'(p), 0, p + 2);
    waitForFlits(p + 2);
    checkRecords($sformatf("%s port %0d", name, p));
  end
endtask

task automatic fixedPriorityTest();
  startTest();
  makePacket(nocArbPkg::PORT_L, 3, 3);
  makePacket(nocArbPkg::PORT_N, 4, 4);
  makePacket(nocArbPkg::PORT_E, 2, 2);
  fork
    sendPacket(nocArbPkg::PORT_L);
    sendPacket(nocArbPkg::PORT_N);
    sendPacket(nocArbPkg::PORT_E);
  join
  expectFlits(nocArbPkg::PORT_L, 0, 3);
  expectFlits(nocArbPkg::PORT_N, 0, 4);
  expectFlits(nocArbPkg::PORT_E, 0, 2);
  waitForFlits(9);
  checkRecords("fixedPriority");
endtask

task automatic rotationTest();
  startTest();
  makePacket(nocArbPkg::PORT_W, 6, 6);
  makePacket(nocArbPkg::PORT_S, 3, 3);
  makePacket(nocArbPkg::PORT_N, 3, 3);
  fork
    sendPacket(nocArbPkg::PORT_W);
    begin
      waitForFlits(1); // W grant under way.
      fork
        sendPacket(nocArbPkg::PORT_S);
        sendPacket(nocArbPkg::PORT_N);
      join
    end
  join
  expectFlits(nocArbPkg::PORT_W, 0, 6);
  expectFlits(nocArbPkg::PORT_S, 0, 3); // S follows W in rotation.
  expectFlits(nocArbPkg::PORT_N, 0, 3);
  waitForFlits(12);
  checkRecords("rotation");
endtask

task automatic lengthLimitTest();
  startTest();
  makePacket(nocArbPkg::PORT_L, 4, 2); // header claims only 2 flits.
  makePacket(nocArbPkg::PORT_N, 2, 2);
  fork
    sendPacket(nocArbPkg::PORT_L);
    sendPacket(nocArbPkg::PORT_N);
  join
  expectFlits(nocArbPkg::PORT_L, 0, 2);
  expectFlits(nocArbPkg::PORT_N, 0, 2);
  expectFlits(nocArbPkg::PORT_L, 2, 2);
  waitForFlits(6);
  checkRecords("lengthLimit");
endtask

task automatic overflowTest();
  int depth;
  depth = dut_i.FIFO_DEPTH;
  startTest();
  makePacket(nocArbPkg::PORT_L, 10, 10);
  makePacket(nocArbPkg::PORT_N, depth + 2, depth);
  fork
    sendPacket(nocArbPkg::PORT_L);
    begin
      waitForFlits(1); // N stays unserved while L streams.
      burstPacket("overflow", nocArbPkg::PORT_N, depth);
    end
  join
  expectFlits(nocArbPkg::PORT_L, 0, 10);
  expectFlits(nocArbPkg::PORT_N, 0, depth);
  waitForFlits(10 + depth);
  checkRecords("overflow");
endtask

// File: verification/nocSwitchTb.sv
`timescale 1ns/1ps

module nocSwitchTb;

  localparam int CLK_PERIOD   = 20;
  localparam int HALF_PERIOD  = CLK_PERIOD / 2;
  localparam int RESET_CYCLES = 5;
  localparam int MAX_FLITS    = 16;
  localparam int QUIET_CYCLES = 8;  // idle time before a test's output is compared.
  localparam int TOTAL_FLITS  = 20 + 9 + 12 + 6 + 16; // flits sent by the five tests.
  localparam int WATCHDOG_CYCLES = 4 * TOTAL_FLITS + 200;

  logic clk;
  logic rst;
  nocFlitPkg::flitData_t [nocArbPkg::NUM_PORTS-1:0]     flitIn;
  nocFlitPkg::flitId_t [nocArbPkg::NUM_PORTS-1:0]       flitIdIn;
  nocFlitPkg::packetLength_t [nocArbPkg::NUM_PORTS-1:0] lengthIn;
  logic [nocArbPkg::NUM_PORTS-1:0]                      flitValid;
  logic [nocArbPkg::NUM_PORTS-1:0]                      full;
  nocFlitPkg::flitData_t                                outFlit;
  nocFlitPkg::flitId_t                                  outId;
  nocArbPkg::portIdx_t                                  outPort;
  logic                                                 outValid;

  int seed;

  // one packet per port, built by the test before it is sent.
  nocFlitPkg::flitData_t     stimData  [nocArbPkg::NUM_PORTS][MAX_FLITS];
  nocFlitPkg::flitId_t       stimId    [nocArbPkg::NUM_PORTS][MAX_FLITS];
  nocFlitPkg::packetLength_t stimLen   [nocArbPkg::NUM_PORTS];
  int                        stimCount [nocArbPkg::NUM_PORTS];

  nocFlitPkg::flitData_t expData[$];
  nocFlitPkg::flitId_t   expId[$];
  nocArbPkg::portIdx_t   expPort[$];
  nocFlitPkg::flitData_t recvData[$];
  nocFlitPkg::flitId_t   recvId[$];
  nocArbPkg::portIdx_t   recvPort[$];

  nocSwitch dut_i (
    .clk       (clk),
    .rst       (rst),
    .flitIn    (flitIn),
    .flitIdIn  (flitIdIn),
    .lengthIn  (lengthIn),
    .flitValid (flitValid),
    .full      (full),
    .outFlit   (outFlit),
    .outId     (outId),
    .outPort   (outPort),
    .outValid  (outValid)
  );

  initial clk = 1'b0;
  always #HALF_PERIOD clk = ~clk;

  // output side is sampled mid cycle.
  always @(negedge clk)
  begin
    if (!rst && outValid)
    begin
      recvData.push_back(outFlit);
      recvId.push_back(outId);
      recvPort.push_back(outPort);
    end
  end

  // ====================
  // failure reporting
  // ====================

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkValue(input string testName, input string what,
                            input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual)
      failRun($sformatf("error %s: %s expected %0h actual %0h",
                        testName, what, expected, actual));
  endtask

  `include "nocSwitchTests.svh"

  // ====================
  // test sequence
  // ====================

  initial
  begin
    seed      = 92;
    rst       = 1'b1;
    flitIn    = '0;
    flitIdIn  = '0;
    lengthIn  = '0;
    flitValid = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    singlePacketTest();
    fixedPriorityTest();
    rotationTest();
    lengthLimitTest();
    overflowTest();
    $display(">>> PASS");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    failRun($sformatf("timeout: the tests did not finish within %0d clock cycles",
                      WATCHDOG_CYCLES));
  end

endmodule
